/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := riscvPipeTb
FILELIST  := sim.f
OBJDIR    := obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

/* hw/corePkg.sv */
package corePkg;

    localparam int IMEM_DEPTH = 256;
    localparam int DMEM_DEPTH = 256;

    typedef logic [$clog2(IMEM_DEPTH)-1:0] imemAddr_t;
    typedef logic [$clog2(DMEM_DEPTH)-1:0] dmemAddr_t;

    // Operand source in execute
    typedef enum logic [1:0] {
        FWD_REG,
        FWD_WB,
        FWD_MEM
    } fwdSel_t;

    // Value written back to the register file
    typedef enum logic [1:0] {
        RES_ALU,
        RES_MEM,
        RES_PC4
    } resultSrc_t;

endpackage

/* hw/executeStage.sv */
`timescale 1ns/100ps

module executeStage import rvIsaPkg::*, corePkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  logic       bubble,
    input  regAddr_t   rs1D,
    input  regAddr_t   rs2D,
    input  regAddr_t   rdD,
    input  word_t      rd1D,
    input  word_t      rd2D,
    input  word_t      immD,
    input  word_t      pcD,
    input  word_t      pcPlus4D,
    input  aluOp_t     aluOpD,
    input  logic       aluSrcD,
    input  logic       regWriteD,
    input  logic       memWriteD,
    input  logic       memReadD,
    input  resultSrc_t resultSrcD,
    input  logic       branchD,
    input  logic       jumpD,
    input  fwdSel_t    fwdA,
    input  fwdSel_t    fwdB,
    input  word_t      resultW,
    output regAddr_t   rs1E,
    output regAddr_t   rs2E,
    output regAddr_t   rdE,
    output logic       memReadE,
    output logic       redirect,
    output word_t      redirectTarget,
    output word_t      aluResultM,
    output word_t      writeDataM,
    output regAddr_t   rdM,
    output logic       regWriteM,
    output logic       memWriteM,
    output resultSrc_t resultSrcM,
    output word_t      pcPlus4M
);

    word_t rd1E, rd2E, immE, pcE, pcPlus4E;
    aluOp_t aluOpE;
    resultSrc_t resultSrcE;
    logic aluSrcE, regWriteE, memWriteE, branchE, jumpE;
    word_t resultM, srcA, srcB, writeDataE, aluResult;

    // Decode/execute register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            {regWriteE, memWriteE, memReadE, branchE, jumpE} <= '0;
        end else begin
            {regWriteE, memWriteE, memReadE, branchE, jumpE} <=
                bubble ? 5'b0 : {regWriteD, memWriteD, memReadD, branchD, jumpD};
        end
    end

    always_ff @(posedge clk) begin
        rs1E <= rs1D;
        rs2E <= rs2D;
        rdE <= rdD;
        rd1E <= rd1D;
        rd2E <= rd2D;
        immE <= immD;
        pcE <= pcD;
        pcPlus4E <= pcPlus4D;
        aluOpE <= aluOpD;
        aluSrcE <= aluSrcD;
        resultSrcE <= resultSrcD;
    end

    // A JAL in memory forwards its link address
    assign resultM = (resultSrcM == RES_PC4) ? pcPlus4M : aluResultM;

    function automatic word_t fwdMux(fwdSel_t sel, word_t regVal);
        case (sel)
            FWD_MEM: return resultM;
            FWD_WB: return resultW;
            default: return regVal;
        endcase
    endfunction

    always_comb begin
        srcA = fwdMux(fwdA, rd1E);
        writeDataE = fwdMux(fwdB, rd2E);
    end

    assign srcB = aluSrcE ? immE : writeDataE;

    always_comb begin
        case (aluOpE)
            ALU_SUB: aluResult = srcA - srcB;
            ALU_AND: aluResult = srcA & srcB;
            ALU_OR: aluResult = srcA | srcB;
            ALU_XOR: aluResult = srcA ^ srcB;
            ALU_SLT: aluResult = word_t'($signed(srcA) < $signed(srcB));
            default: aluResult = srcA + srcB;
        endcase
    end

    // BEQ compares through the subtract
    assign redirect = jumpE || (branchE && aluResult == '0);
    assign redirectTarget = pcE + immE;

    // Execute/memory register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteM <= 1'b0;
            memWriteM <= 1'b0;
        end else begin
            regWriteM <= regWriteE;
            memWriteM <= memWriteE;
        end
    end

    always_ff @(posedge clk) begin
        aluResultM <= aluResult;
        writeDataM <= writeDataE;
        rdM <= rdE;
        resultSrcM <= resultSrcE;
        pcPlus4M <= pcPlus4E;
    end

    // The flushed slot behind a redirect never redirects
    assert property (@(posedge clk) disable iff (!rstN) redirect |=> !redirect);

endmodule

/* hw/fetchStage.sv */
`timescale 1ns/100ps

module fetchStage import rvIsaPkg::*, corePkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      stall,
    input  logic      flushD,
    input  logic      redirect,
    input  word_t     redirectTarget,
    input  logic      imemWe,
    input  imemAddr_t imemAddr,
    input  word_t     imemData,
    output word_t     instrD,
    output word_t     pcD,
    output word_t     pcPlus4D
);

    word_t imem [IMEM_DEPTH];
    word_t pcF;
    word_t pcPlus4F;
    word_t instrF;

    assign pcPlus4F = pcF + 32'd4;
    assign instrF = imem[imemAddr_t'(pcF[31:2])];

    always_ff @(posedge clk) begin
        if (imemWe) begin
            imem[imemAddr] <= imemData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pcF <= '0;
        end else if (redirect) begin
            pcF <= redirectTarget;
        end else if (!stall) begin
            pcF <= pcPlus4F;
        end
    end

    // A flush turns the fetch/decode register into a nop
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            instrD <= NOP_INSTR;
        end else if (flushD) begin
            instrD <= NOP_INSTR;
        end else if (!stall) begin
            instrD <= instrF;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall) begin
            pcD <= pcF;
            pcPlus4D <= pcPlus4F;
        end
    end

    // Program is loaded only while the core is held in reset
    assert property (@(posedge clk) imemWe |-> !rstN);

endmodule

/* hw/memoryStage.sv */
`timescale 1ns/100ps

module memoryStage import rvIsaPkg::*, corePkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  word_t      aluResultM,
    input  word_t      writeDataM,
    input  regAddr_t   rdM,
    input  logic       regWriteM,
    input  logic       memWriteM,
    input  resultSrc_t resultSrcM,
    input  word_t      pcPlus4M,
    output regAddr_t   rdW,
    output logic       regWriteW,
    output word_t      resultW,
    output logic       wbValid,
    output regAddr_t   wbRd,
    output word_t      wbData
);

    word_t dmem [DMEM_DEPTH];
    dmemAddr_t dmemAddr;
    word_t readDataM;
    word_t resultM;

    // Word index with the byte offset ignored
    assign dmemAddr = dmemAddr_t'(aluResultM[31:2]);
    assign readDataM = dmem[dmemAddr];

    always_ff @(posedge clk) begin
        if (memWriteM) begin
            dmem[dmemAddr] <= writeDataM;
        end
    end

    always_comb begin
        case (resultSrcM)
            RES_MEM: resultM = readDataM;
            RES_PC4: resultM = pcPlus4M;
            default: resultM = aluResultM;
        endcase
    end

    // Memory/writeback register
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            regWriteW <= 1'b0;
        end else begin
            regWriteW <= regWriteM;
        end
    end

    always_ff @(posedge clk) begin
        rdW <= rdM;
        resultW <= resultM;
    end

    assign wbValid = regWriteW && rdW != '0;
    assign wbRd = rdW;
    assign wbData = resultW;

endmodule

/* hw/pipelineControl.sv */
`timescale 1ns/100ps

module pipelineControl import rvIsaPkg::*, corePkg::*; (
    input  logic       clk,
    input  logic       rstN,
    input  word_t      instrD,
    input  regAddr_t   rs1E,
    input  regAddr_t   rs2E,
    input  regAddr_t   rdE,
    input  regAddr_t   rdM,
    input  regAddr_t   rdW,
    input  logic       memReadE,
    input  logic       regWriteM,
    input  logic       regWriteW,
    input  logic       redirect,
    output regAddr_t   rs1D,
    output regAddr_t   rs2D,
    output regAddr_t   rdD,
    output word_t      immD,
    output aluOp_t     aluOpD,
    output logic       aluSrcD,
    output logic       regWriteD,
    output logic       memWriteD,
    output logic       memReadD,
    output resultSrc_t resultSrcD,
    output logic       branchD,
    output logic       jumpD,
    output fwdSel_t    fwdA,
    output fwdSel_t    fwdB,
    output logic       stall,
    output logic       flushD,
    output logic       bubble
);

    opcode_t opcode;
    funct3_t funct3;
    logic usesRs1;
    logic usesRs2;
    logic loadUse;

    assign opcode = instrD[6:0];
    assign funct3 = instrD[14:12];
    assign rs1D = instrD[19:15];
    assign rs2D = instrD[24:20];
    assign rdD = instrD[11:7];

    always_comb begin
        aluOpD = ALU_ADD;
        aluSrcD = 1'b0;
        regWriteD = 1'b0;
        memWriteD = 1'b0;
        memReadD = 1'b0;
        resultSrcD = RES_ALU;
        branchD = 1'b0;
        jumpD = 1'b0;
        usesRs1 = 1'b0;
        usesRs2 = 1'b0;
        immD = {{20{instrD[31]}}, instrD[31:20]};
        case (opcode)
            OP_REG: begin
                regWriteD = 1'b1;
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
                case (funct3)
                    F3_ADD: aluOpD = instrD[30] ? ALU_SUB : ALU_ADD;
                    F3_SLT: aluOpD = ALU_SLT;
                    F3_XOR: aluOpD = ALU_XOR;
                    F3_OR: aluOpD = ALU_OR;
                    F3_AND: aluOpD = ALU_AND;
                    default: regWriteD = 1'b0;
                endcase
            end
            OP_IMM: begin
                // Only ADDI in this subset
                regWriteD = (funct3 == F3_ADD);
                aluSrcD = 1'b1;
                usesRs1 = 1'b1;
            end
            OP_LOAD: begin
                regWriteD = (funct3 == F3_WORD);
                memReadD = (funct3 == F3_WORD);
                aluSrcD = 1'b1;
                resultSrcD = RES_MEM;
                usesRs1 = 1'b1;
            end
            OP_STORE: begin
                memWriteD = (funct3 == F3_WORD);
                aluSrcD = 1'b1;
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
                immD = {{20{instrD[31]}}, instrD[31:25], instrD[11:7]};
            end
            OP_BRANCH: begin
                branchD = (funct3 == F3_BEQ);
                aluOpD = ALU_SUB;
                usesRs1 = 1'b1;
                usesRs2 = 1'b1;
                immD = {{19{instrD[31]}}, instrD[31], instrD[7], instrD[30:25],
                        instrD[11:8], 1'b0};
            end
            OP_JAL: begin
                jumpD = 1'b1;
                regWriteD = 1'b1;
                resultSrcD = RES_PC4;
                immD = {{11{instrD[31]}}, instrD[31], instrD[19:12], instrD[20],
                        instrD[30:21], 1'b0};
            end
            default: ;
        endcase
    end

    assign loadUse = memReadE && rdE != '0 &&
                     ((usesRs1 && rdE == rs1D) || (usesRs2 && rdE == rs2D));

    // Redirect wins over a load-use stall
    assign stall = loadUse && !redirect;
    assign flushD = redirect;
    assign bubble = loadUse || redirect;

    // Memory stage is the younger result
    function automatic fwdSel_t pickFwd(regAddr_t rs);
        if (regWriteM && rdM != '0 && rdM == rs) begin
            return FWD_MEM;
        end
        if (regWriteW && rdW != '0 && rdW == rs) begin
            return FWD_WB;
        end
        return FWD_REG;
    endfunction

    always_comb begin
        fwdA = pickFwd(rs1E);
        fwdB = pickFwd(rs2E);
    end

    // The bubble behind a load clears the hazard
    assert property (@(posedge clk) disable iff (!rstN) stall |=> !stall);
    assert property (@(posedge clk) disable iff (!rstN) !(stall && flushD));
    assert property (@(posedge clk) disable iff (!rstN) fwdA == FWD_MEM |-> rdM != '0);

endmodule

/* hw/regFile.sv */
`timescale 1ns/100ps

module regFile import rvIsaPkg::*; (
    input  logic     clk,
    input  regAddr_t rs1D,
    input  regAddr_t rs2D,
    input  regAddr_t rdW,
    input  logic     regWriteW,
    input  word_t    resultW,
    output word_t    rd1D,
    output word_t    rd2D
);

    word_t regs [32];

    always_ff @(posedge clk) begin
        if (regWriteW && rdW != '0) begin
            regs[rdW] <= resultW;
        end
    end

    // Writeback in the same cycle goes straight to the reader
    function automatic word_t readPort(regAddr_t rs);
        if (rs == '0) begin
            return '0;
        end
        if (regWriteW && rdW == rs) begin
            return resultW;
        end
        return regs[rs];
    endfunction

    always_comb begin
        rd1D = readPort(rs1D);
        rd2D = readPort(rs2D);
    end

    // The x0 entry keeps its contents through a write to x0
    assert property (@(posedge clk) regWriteW && rdW == '0 |=> regs[0] === $past(regs[0]));

endmodule

/* hw/riscvPipe.sv */
`timescale 1ns/100ps

module riscvPipe import rvIsaPkg::*, corePkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      imemWe,
    input  imemAddr_t imemAddr,
    input  word_t     imemData,
    output logic      wbValid,
    output regAddr_t  wbRd,
    output word_t     wbData
);

    // Decode
    word_t instrD, pcD, pcPlus4D;
    word_t rd1D, rd2D, immD;
    regAddr_t rs1D, rs2D, rdD;
    aluOp_t aluOpD;
    resultSrc_t resultSrcD;
    logic aluSrcD, regWriteD, memWriteD, memReadD, branchD, jumpD;

    // Hazard and redirect
    fwdSel_t fwdA, fwdB;
    logic stall, flushD, bubble, redirect;
    word_t redirectTarget;

    // Execute
    regAddr_t rs1E, rs2E, rdE;
    logic memReadE;

    // Memory
    word_t aluResultM, writeDataM, pcPlus4M;
    regAddr_t rdM;
    resultSrc_t resultSrcM;
    logic regWriteM, memWriteM;

    // Writeback
    regAddr_t rdW;
    logic regWriteW;
    word_t resultW;

    // All port names match the nets above
    pipelineControl control (.*);

    fetchStage fetch (.*);

    regFile registers (.*);

    executeStage execute (.*);

    memoryStage memory (.*);

endmodule

/* hw/rvIsaPkg.sv */
package rvIsaPkg;

    localparam int XLEN = 32;
    localparam int REG_ADDR_W = 5;
    localparam int OPCODE_W = 7;

    typedef logic [XLEN-1:0] word_t;
    typedef logic [REG_ADDR_W-1:0] regAddr_t;
    typedef logic [OPCODE_W-1:0] opcode_t;
    typedef logic [2:0] funct3_t;

    localparam opcode_t OP_REG    = 7'b0110011;
    localparam opcode_t OP_IMM    = 7'b0010011;
    localparam opcode_t OP_LOAD   = 7'b0000011;
    localparam opcode_t OP_STORE  = 7'b0100011;
    localparam opcode_t OP_BRANCH = 7'b1100011;
    localparam opcode_t OP_JAL    = 7'b1101111;

    // ALU group funct3
    localparam funct3_t F3_ADD = 3'b000;
    localparam funct3_t F3_SLT = 3'b010;
    localparam funct3_t F3_XOR = 3'b100;
    localparam funct3_t F3_OR  = 3'b110;
    localparam funct3_t F3_AND = 3'b111;

    // Word access and BEQ
    localparam funct3_t F3_WORD = 3'b010;
    localparam funct3_t F3_BEQ  = 3'b000;

    // addi x0, x0, 0
    localparam word_t NOP_INSTR = 32'h0000_0013;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLT
    } aluOp_t;

endpackage

/* sim.f */
hw/rvIsaPkg.sv
hw/corePkg.sv
hw/pipelineControl.sv
hw/fetchStage.sv
hw/regFile.sv
hw/executeStage.sv
hw/memoryStage.sv
hw/riscvPipe.sv
tb/riscvPipeTb.sv

/* tb/pipeCases.txt */
# Each case gives its word count, the program words and the writeback count
# and then one rd and value pair per expected writeback, all in hex
# ALU operations with forwarding from memory and writeback
a
00500093 ffd00113 002081b3 40118233 001272b3
00316333 001343b3 00112433 0020a4b3 0000006f
9
01 00000005  02 fffffffd  03 00000002  04 fffffffd  05 00000005
06 ffffffff  07 fffffffa  08 00000001  09 00000000
# Store then load with a load-use stall and a write to x0
8
04000093 12300113 0020a223 0040a183 00318233 00700013 000202b3 0000006f
5
01 00000040  02 00000123  03 00000123  04 00000246  05 00000246
# Taken and untaken BEQ and a JAL with its link value
d
00100093 00100113 00208663 03300193 04400213 00200293 00128463
00300313 00c003ef 05500193 06600213 00638433 0000006f
6
01 00000001  02 00000001  05 00000002  06 00000003  07 00000024  08 00000027

/* tb/riscvPipeTb.sv */
`timescale 1ns/100ps

module riscvPipeTb import rvIsaPkg::*, corePkg::*; ();

    localparam int resetCycles = 16;
    localparam int drainCycles = 8;

    logic clk;
    logic rstN;
    logic imemWe;
    imemAddr_t imemAddr;
    word_t imemData;
    logic wbValid;
    regAddr_t wbRd;
    word_t wbData;

    // Cases as loaded from the file
    word_t progWords[$];
    int progStart[$];
    int progLen[$];
    regAddr_t expRd[$];
    word_t expData[$];
    int expStart[$];
    int expLen[$];

    int casesFd;
    int lookChar;
    int cycleCount = 0;
    int cycleLimit = 0;

    riscvPipe dut_i (
        .clk(clk),
        .rstN(rstN),
        .imemWe(imemWe),
        .imemAddr(imemAddr),
        .imemData(imemData),
        .wbValid(wbValid),
        .wbRd(wbRd),
        .wbData(wbData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic failRun();
        $display("Simulation failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    always @(posedge clk) begin
        cycleCount++;
        if (cycleLimit > 0 && cycleCount > cycleLimit) begin
            $display("Timeout after %0d cycles, the expected writebacks never arrived",
                     cycleCount);
            failRun();
        end
    end

    function automatic bit isSpaceChar(int c);
        return c == int'(" ") || c == int'("\t") || c == int'("\n") || c == int'("\r");
    endfunction

    function automatic bit isHexChar(int c);
        return (c >= int'("0") && c <= int'("9")) ||
               (c >= int'("a") && c <= int'("f")) ||
               (c >= int'("A") && c <= int'("F"));
    endfunction

    function automatic logic [3:0] hexNibble(int c);
        if (c >= int'("0") && c <= int'("9")) begin
            return 4'(c - int'("0"));
        end
        if (c >= int'("a") && c <= int'("f")) begin
            return 4'(c - int'("a") + 10);
        end
        return 4'(c - int'("A") + 10);
    endfunction

    // Reads the next hex token past blanks and # comments
    task automatic readToken(output word_t value, output bit found);
        value = '0;
        found = 1'b0;
        forever begin
            if (lookChar == int'("#")) begin
                while (lookChar != int'("\n") && lookChar != -1) begin
                    lookChar = $fgetc(casesFd);
                end
            end else if (isSpaceChar(lookChar)) begin
                lookChar = $fgetc(casesFd);
            end else begin
                break;
            end
        end
        while (isHexChar(lookChar)) begin
            value = {value[27:0], hexNibble(lookChar)};
            found = 1'b1;
            lookChar = $fgetc(casesFd);
        end
    endtask

    task automatic readField(output word_t value);
        bit found;
        readToken(value, found);
        if (!found) begin
            $display("Cases file ends inside a case or holds a field that is not hex");
            failRun();
        end
    endtask

    task automatic loadCases();
        word_t value;
        bit found;
        int nWords;
        int nExp;
        int totalWords;
        casesFd = $fopen("tb/pipeCases.txt", "r");
        if (casesFd == 0) begin
            $display("Cannot open the cases file tb/pipeCases.txt");
            failRun();
        end
        lookChar = $fgetc(casesFd);
        totalWords = 0;
        forever begin
            readToken(value, found);
            if (!found) begin
                break;
            end
            nWords = int'(value);
            if (nWords < 1 || nWords > resetCycles) begin
                $display("Case %0d has %0d program words, which do not fit the reset window",
                         progLen.size(), nWords);
                failRun();
            end
            progStart.push_back(progWords.size());
            progLen.push_back(nWords);
            repeat (nWords) begin
                readField(value);
                progWords.push_back(value);
            end
            readField(value);
            nExp = int'(value);
            expStart.push_back(expRd.size());
            expLen.push_back(nExp);
            repeat (nExp) begin
                readField(value);
                expRd.push_back(regAddr_t'(value));
                readField(value);
                expData.push_back(value);
            end
            totalWords += nWords;
        end
        if (lookChar != -1) begin
            $display("Cases file holds a character that is not a hex digit");
            failRun();
        end
        $fclose(casesFd);
        if (progLen.size() == 0) begin
            $display("Cases file holds no cases");
            failRun();
        end
        cycleLimit = 40 * progLen.size() + 6 * totalWords;
    endtask

    task automatic checkValue(string name, word_t expected, word_t actual);
        assert (actual === expected) else begin
            $display("Fail at %0t: %s expected %h, got %h", $time, name, expected, actual);
            failRun();
        end
    endtask

    task automatic runCase(int caseIdx);
        int cyc;
        int expIdx;
        int pos;
        @(negedge clk);
        rstN = 1'b0;
        // Program goes in while the core is held in reset
        for (cyc = 0; cyc < resetCycles; cyc++) begin
            if (cyc < progLen[caseIdx]) begin
                imemWe = 1'b1;
                imemAddr = imemAddr_t'(cyc);
                imemData = progWords[progStart[caseIdx] + cyc];
            end else begin
                imemWe = 1'b0;
            end
            @(negedge clk);
        end
        imemWe = 1'b0;
        rstN = 1'b1;
        expIdx = 0;
        while (expIdx < expLen[caseIdx]) begin
            @(negedge clk);
            if (wbValid) begin
                pos = expStart[caseIdx] + expIdx;
                checkValue("wbRd", word_t'(expRd[pos]), word_t'(wbRd));
                checkValue("wbData", expData[pos], wbData);
                expIdx++;
            end
        end
        // Nothing may write back once the list is done
        repeat (drainCycles) begin
            @(negedge clk);
            assert (!wbValid) else begin
                $display("Case %0d wrote x%0d after all expected writebacks had arrived",
                         caseIdx, wbRd);
                failRun();
            end
        end
        $display("Case %0d done with %0d writebacks", caseIdx, expLen[caseIdx]);
    endtask

    initial begin
        int caseIdx;
        rstN = 1'b0;
        imemWe = 1'b0;
        imemAddr = '0;
        imemData = '0;
        loadCases();
        for (caseIdx = 0; caseIdx < progLen.size(); caseIdx++) begin
            runCase(caseIdx);
        end
        $display("Simulation completed successfully");
        $finish;
    end

endmodule
